//--- Makefile
VERILATOR ?= verilator
TOP       ?= utm_core_tb
FLAGS     ?= --binary --timing --assert
FILE_LIST ?= list.f

BIN     := obj_dir/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# succeeds only when the pass line shows up in the output
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- list.f
+incdir+verilog
verilog/utm_pkg.sv
verilog/utm_transition_table.sv
verilog/utm_step_control.sv
verilog/utm_core.sv
tests/utm_core_asserts.sv
tests/utm_core_tb.sv

//--- tests/utm_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "utm_params.svh"

module utm_core_asserts (
    input logic                clock,
    input logic                reset,
    input utm_pkg::utm_mode_t  mode,
    input logic                symbol_valid,
    input utm_pkg::utm_state_t stored_state,
    input logic                buffer_valid
);

    import utm_pkg::*;

    int failures = 0;

    // lookup mode parks the state register
    lookup_clears_state: assert property (@(posedge clock)
        mode == mode_lookup |=> stored_state == utm_state_t'(`UTM_RESET_STATE))
        else begin
            failures++;
            $error("stored state not at reset value after a lookup cycle");
        end

    idle_holds_state: assert property (@(posedge clock) disable iff (reset)
        (mode == mode_step && !symbol_valid) |=> $stable(stored_state))
        else begin
            failures++;
            $error("stored state moved without a strobe");
        end

    // first strobe only fills the buffer
    first_strobe_holds_state: assert property (@(posedge clock) disable iff (reset)
        (mode == mode_step && symbol_valid && !buffer_valid) |=> $stable(stored_state))
        else begin
            failures++;
            $error("stored state moved on a strobe into an empty buffer");
        end

endmodule

`default_nettype wire

//--- tests/utm_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module utm_core_tb;

    import utm_pkg::*;

    localparam int    HALF_PERIOD    = 20;
    localparam int    SETTLE         = 10;
    localparam int    RESET_CYCLES   = 5;
    localparam int    RESET_TIMEOUT  = 20;
    localparam int    VECTOR_TIMEOUT = 200;
    localparam int    VECTOR_COUNT   = 83;
    localparam string STIMULUS_FILE  = "tests/utm_stimulus.txt";

    logic        clock;
    logic        reset;
    utm_mode_t   mode;
    utm_state_t  state_in;
    utm_symbol_t symbol_in;
    logic        symbol_valid;
    utm_rule_t   rule;

    int    error_count;
    int    check_count;
    int    test_count;
    int    test_checks;
    int    test_errors;
    string current_test;
    logic  reset_timed_out;

    utm_core UUT (
        .clock        (clock),
        .reset        (reset),
        .mode         (mode),
        .state_in     (state_in),
        .symbol_in    (symbol_in),
        .symbol_valid (symbol_valid),
        .rule         (rule)
    );

    bind utm_core utm_core_asserts step_asserts (
        .clock        (clock),
        .reset        (reset),
        .mode         (mode),
        .symbol_valid (symbol_valid),
        .stored_state (step_control.stored_state),
        .buffer_valid (step_control.buffer_valid)
    );

    initial clock = 1'b0;

    always #HALF_PERIOD clock = ~clock;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

    task automatic check_value(input string test_name, input utm_rule_t expected,
                               input utm_rule_t actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("Error: test %s expected %h actual %h", test_name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (current_test != "") begin
            $display("test %s: %0d checks, %0d errors", current_test, test_checks,
                     test_errors);
            test_count++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset still asserted after %0d cycles", RESET_TIMEOUT);
            error_count++;
            reset_timed_out = 1'b1;
        end
    endtask

    task automatic run_vectors();
        int        fd;
        int        fields;
        int        vectors;
        string     line;
        string     name;
        int        mode_value;
        int        valid_value;
        int        state_value;
        int        symbol_value;
        int        next_value;
        int        write_value;
        int        move_value;
        utm_rule_t expected;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIMULUS_FILE);
            error_count++;
            return;
        end
        vectors = 0;
        while ($fgets(line, fd) > 0) begin
            if (vectors >= VECTOR_TIMEOUT) begin
                $display("stimulus loop stopped after %0d cycles", VECTOR_TIMEOUT);
                error_count++;
                break;
            end
            if (line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %d %d %d %d %d %d %d", name, mode_value,
                             valid_value, state_value, symbol_value, next_value,
                             write_value, move_value);
            if (fields <= 0) begin
                continue;
            end
            if (fields != 8) begin
                $display("malformed stimulus line after vector %0d", vectors);
                error_count++;
                continue;
            end
            if (name != current_test) begin
                close_test();
                current_test = name;
            end
            @(posedge clock);
            mode         <= utm_mode_t'(mode_value[0]);
            symbol_valid <= valid_value[0];
            state_in     <= utm_state_t'(state_value[2:0]);
            symbol_in    <= utm_symbol_t'(symbol_value[2:0]);
            #SETTLE;
            expected = '{utm_state_t'(next_value[2:0]), utm_symbol_t'(write_value[2:0]),
                         utm_move_t'(move_value[0])};
            check_value(name, expected, rule);
            vectors++;
        end
        $fclose(fd);
        close_test();
        if (vectors != VECTOR_COUNT) begin
            $display("stimulus file gave %0d vectors instead of %0d", vectors, VECTOR_COUNT);
            error_count++;
        end
    endtask

    initial begin
        mode            = mode_step;
        state_in        = state_a;
        symbol_in       = '0;
        symbol_valid    = 1'b0;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        test_checks     = 0;
        test_errors     = 0;
        current_test    = "";
        reset_timed_out = 1'b0;
        wait_for_reset();
        if (!reset_timed_out) begin
            run_vectors();
        end
        if (UUT.step_asserts.failures != 0) begin
            $display("concurrent assertions failed %0d times", UUT.step_asserts.failures);
            error_count += UUT.step_asserts.failures;
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/utm_stimulus.txt
# test mode valid state_in symbol_in next_state write_symbol move (decimal, one cycle a line)
# mode 0 is lookup and 1 is step, move 0 is left and 1 is right
reset_view 1 0 0 0 1 2 0
lookup_table 0 0 0 0 1 2 0
lookup_table 0 0 0 1 2 2 0
lookup_table 0 0 0 2 0 2 1
lookup_table 0 0 0 4 4 0 0
lookup_table 0 0 0 5 0 1 1
lookup_table 0 0 0 6 0 1 1
lookup_table 0 0 0 7 0 7 1
lookup_table 0 0 1 0 1 4 0
lookup_table 0 0 1 1 1 5 0
lookup_table 0 0 1 2 3 4 0
lookup_table 0 0 1 4 6 0 1
lookup_table 0 0 1 5 7 1 1
lookup_table 0 0 1 6 1 6 0
lookup_table 0 0 1 7 1 6 0
lookup_table 0 0 2 0 2 4 0
lookup_table 0 0 2 1 2 5 0
lookup_table 0 0 2 2 1 4 0
lookup_table 0 0 2 4 6 4 1
lookup_table 0 0 2 5 7 5 1
lookup_table 0 0 2 6 2 6 0
lookup_table 0 0 2 7 2 6 0
lookup_table 0 0 3 0 2 0 1
lookup_table 0 0 3 1 4 5 1
lookup_table 0 0 3 2 0 2 1
lookup_table 0 0 3 4 3 2 0
lookup_table 0 0 3 5 3 5 0
lookup_table 0 0 3 6 3 6 0
lookup_table 0 0 3 7 3 7 0
lookup_table 0 0 4 0 3 0 1
lookup_table 0 0 4 1 5 5 0
lookup_table 0 0 4 2 4 4 1
lookup_table 0 0 4 4 4 4 1
lookup_table 0 0 4 5 4 5 1
lookup_table 0 0 4 6 3 7 0
lookup_table 0 0 4 7 4 7 1
lookup_table 0 0 5 0 5 4 0
lookup_table 0 0 5 1 5 5 0
lookup_table 0 0 5 2 5 4 0
lookup_table 0 0 5 4 1 0 1
lookup_table 0 0 5 5 1 1 1
lookup_table 0 0 5 6 5 6 0
lookup_table 0 0 5 7 6 6 1
lookup_table 0 0 6 0 0 0 1
lookup_table 0 0 6 1 0 1 1
lookup_table 0 0 6 2 5 0 0
lookup_table 0 0 6 4 6 0 1
lookup_table 0 0 6 5 6 1 1
lookup_table 0 0 6 6 6 6 1
lookup_table 0 0 6 7 6 7 1
lookup_table 0 0 7 0 0 0 0
lookup_table 0 0 7 1 0 1 0
lookup_table 0 0 7 2 5 1 0
lookup_table 0 0 7 4 7 0 1
lookup_table 0 0 7 5 7 1 1
lookup_table 0 0 7 6 7 6 1
lookup_table 0 0 7 7 7 1 1
first_strobe 1 0 7 7 1 2 0
first_strobe 1 1 7 5 1 2 0
first_strobe 1 0 7 7 0 1 1
stepping 1 1 7 1 0 1 1
stepping 1 0 7 7 2 2 0
stepping 1 1 7 2 2 2 0
stepping 1 0 7 7 1 4 0
stepping 1 1 7 4 1 4 0
stepping 1 1 7 0 6 0 1
stepping 1 0 7 7 0 0 1
stepping 1 1 7 6 0 0 1
stepping 1 1 7 4 0 1 1
stepping 1 1 7 1 4 0 0
stepping 1 0 7 7 5 5 0
mode_reentry 0 1 5 2 5 4 0
mode_reentry 1 0 7 7 1 2 0
mode_reentry 1 1 7 2 1 2 0
mode_reentry 1 0 7 7 0 2 1
unused_symbol 0 0 2 3 2 0 0
unused_symbol 0 0 6 3 6 0 0
unused_symbol 1 0 7 7 1 2 0
unused_symbol 1 1 7 4 1 2 0
unused_symbol 1 1 7 3 4 0 0
unused_symbol 1 0 7 7 4 0 0
unused_symbol 1 1 7 0 4 0 0
unused_symbol 1 0 7 7 3 0 1

//--- verilog/utm_core.sv
`timescale 1ns/1ps
`default_nettype none

module utm_core (
    input  logic                 clock,
    input  logic                 reset,
    input  utm_pkg::utm_mode_t   mode,
    input  utm_pkg::utm_state_t  state_in,
    input  utm_pkg::utm_symbol_t symbol_in,
    input  logic                 symbol_valid,
    output utm_pkg::utm_rule_t   rule
);

    import utm_pkg::*;

    utm_state_t  table_state;
    utm_symbol_t table_symbol;

    utm_step_control step_control (
        .clock        (clock),
        .reset        (reset),
        .mode         (mode),
        .state_in     (state_in),
        .symbol_in    (symbol_in),
        .symbol_valid (symbol_valid),
        .next_state   (rule.next_state),
        .table_state  (table_state),
        .table_symbol (table_symbol)
    );

    // same rule drives the output and the state update
    utm_transition_table transition_table (
        .state  (table_state),
        .symbol (table_symbol),
        .rule   (rule)
    );

endmodule

`default_nettype wire

//--- verilog/utm_params.svh
`ifndef UTM_PARAMS_SVH
`define UTM_PARAMS_SVH

// encoded field widths
`define UTM_STATE_WIDTH 3
`define UTM_SYMBOL_WIDTH 3

// register contents after reset and while in lookup mode
`define UTM_RESET_STATE 0
`define UTM_BLANK_SYMBOL 0

`endif

//--- verilog/utm_pkg.sv
`default_nettype none

`include "utm_params.svh"

package utm_pkg;

    // dense binary state index
    typedef enum logic [`UTM_STATE_WIDTH-1:0] {
        state_a,
        state_b,
        state_c,
        state_d,
        state_e,
        state_f,
        state_g,
        state_h
    } utm_state_t;

    typedef logic [`UTM_SYMBOL_WIDTH-1:0] utm_symbol_t;

    typedef enum logic {
        move_left  = 1'b0,
        move_right = 1'b1
    } utm_move_t;

    typedef enum logic {
        mode_lookup = 1'b0,
        mode_step   = 1'b1
    } utm_mode_t;

    // one table entry
    typedef struct packed {
        utm_state_t  next_state;
        utm_symbol_t write_symbol;
        utm_move_t   move;
    } utm_rule_t;

endpackage

`default_nettype wire

//--- verilog/utm_step_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "utm_params.svh"

module utm_step_control (
    input  logic                 clock,
    input  logic                 reset,
    input  utm_pkg::utm_mode_t   mode,
    input  utm_pkg::utm_state_t  state_in,
    input  utm_pkg::utm_symbol_t symbol_in,
    input  logic                 symbol_valid,
    input  utm_pkg::utm_state_t  next_state,
    output utm_pkg::utm_state_t  table_state,
    output utm_pkg::utm_symbol_t table_symbol
);

    import utm_pkg::*;

    utm_state_t  stored_state;
    utm_symbol_t symbol_buffer;
    logic        buffer_valid;
    logic        clear;

    // lookup mode keeps the step registers parked as in reset
    assign clear = reset || (mode == mode_lookup);

    always_ff @(posedge clock) begin
        if (clear) begin
            stored_state  <= utm_state_t'(`UTM_RESET_STATE);
            symbol_buffer <= utm_symbol_t'(`UTM_BLANK_SYMBOL);
            buffer_valid  <= 1'b0;
        end else if (symbol_valid) begin
            symbol_buffer <= symbol_in;
            buffer_valid  <= 1'b1;
            // next_state was looked up with the old buffered symbol
            if (buffer_valid) begin
                stored_state <= next_state;
            end
        end
    end

    // operand select
    always_comb begin
        if (mode == mode_step) begin
            table_state  = stored_state;
            table_symbol = symbol_buffer;
        end else begin
            table_state  = state_in;
            table_symbol = symbol_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/utm_transition_table.sv
`timescale 1ns/1ps
`default_nettype none

module utm_transition_table (
    input  utm_pkg::utm_state_t  state,
    input  utm_pkg::utm_symbol_t symbol,
    output utm_pkg::utm_rule_t   rule
);

    import utm_pkg::*;

    // symbol 3 keeps the state and writes a blank moving left
    utm_rule_t unused_rule;

    assign unused_rule = '{state, 3'd0, move_left};

    always_comb begin
        case (state)
            state_a: begin
                case (symbol)
                    3'd0:    rule = '{state_b, 3'd2, move_left};
                    3'd1:    rule = '{state_c, 3'd2, move_left};
                    3'd2:    rule = '{state_a, 3'd2, move_right};
                    3'd4:    rule = '{state_e, 3'd0, move_left};
                    3'd5:    rule = '{state_a, 3'd1, move_right};
                    3'd6:    rule = '{state_a, 3'd1, move_right};
                    3'd7:    rule = '{state_a, 3'd7, move_right};
                    default: rule = unused_rule;
                endcase
            end
            state_b: begin
                case (symbol)
                    3'd0:    rule = '{state_b, 3'd4, move_left};
                    3'd1:    rule = '{state_b, 3'd5, move_left};
                    3'd2:    rule = '{state_d, 3'd4, move_left};
                    3'd4:    rule = '{state_g, 3'd0, move_right};
                    3'd5:    rule = '{state_h, 3'd1, move_right};
                    3'd6:    rule = '{state_b, 3'd6, move_left};
                    3'd7:    rule = '{state_b, 3'd6, move_left};
                    default: rule = unused_rule;
                endcase
            end
            state_c: begin
                case (symbol)
                    3'd0:    rule = '{state_c, 3'd4, move_left};
                    3'd1:    rule = '{state_c, 3'd5, move_left};
                    3'd2:    rule = '{state_b, 3'd4, move_left};
                    3'd4:    rule = '{state_g, 3'd4, move_right};
                    3'd5:    rule = '{state_h, 3'd5, move_right};
                    3'd6:    rule = '{state_c, 3'd6, move_left};
                    3'd7:    rule = '{state_c, 3'd6, move_left};
                    default: rule = unused_rule;
                endcase
            end
            state_d: begin
                case (symbol)
                    3'd0:    rule = '{state_c, 3'd0, move_right};
                    3'd1:    rule = '{state_e, 3'd5, move_right};
                    3'd2:    rule = '{state_a, 3'd2, move_right};
                    3'd4:    rule = '{state_d, 3'd2, move_left};
                    3'd5:    rule = '{state_d, 3'd5, move_left};
                    3'd6:    rule = '{state_d, 3'd6, move_left};
                    3'd7:    rule = '{state_d, 3'd7, move_left};
                    default: rule = unused_rule;
                endcase
            end
            state_e: begin
                case (symbol)
                    3'd0:    rule = '{state_d, 3'd0, move_right};
                    3'd1:    rule = '{state_f, 3'd5, move_left};
                    3'd2:    rule = '{state_e, 3'd4, move_right};
                    3'd4:    rule = '{state_e, 3'd4, move_right};
                    3'd5:    rule = '{state_e, 3'd5, move_right};
                    3'd6:    rule = '{state_d, 3'd7, move_left};
                    3'd7:    rule = '{state_e, 3'd7, move_right};
                    default: rule = unused_rule;
                endcase
            end
            state_f: begin
                case (symbol)
                    3'd0:    rule = '{state_f, 3'd4, move_left};
                    3'd1:    rule = '{state_f, 3'd5, move_left};
                    3'd2:    rule = '{state_f, 3'd4, move_left};
                    3'd4:    rule = '{state_b, 3'd0, move_right};
                    3'd5:    rule = '{state_b, 3'd1, move_right};
                    3'd6:    rule = '{state_f, 3'd6, move_left};
                    3'd7:    rule = '{state_g, 3'd6, move_right};
                    default: rule = unused_rule;
                endcase
            end
            state_g: begin
                case (symbol)
                    3'd0:    rule = '{state_a, 3'd0, move_right};
                    3'd1:    rule = '{state_a, 3'd1, move_right};
                    3'd2:    rule = '{state_f, 3'd0, move_left};
                    3'd4:    rule = '{state_g, 3'd0, move_right};
                    3'd5:    rule = '{state_g, 3'd1, move_right};
                    3'd6:    rule = '{state_g, 3'd6, move_right};
                    3'd7:    rule = '{state_g, 3'd7, move_right};
                    default: rule = unused_rule;
                endcase
            end
            state_h: begin
                case (symbol)
                    3'd0:    rule = '{state_a, 3'd0, move_left};
                    3'd1:    rule = '{state_a, 3'd1, move_left};
                    3'd2:    rule = '{state_f, 3'd1, move_left};
                    3'd4:    rule = '{state_h, 3'd0, move_right};
                    3'd5:    rule = '{state_h, 3'd1, move_right};
                    3'd6:    rule = '{state_h, 3'd6, move_right};
                    3'd7:    rule = '{state_h, 3'd1, move_right};
                    default: rule = unused_rule;
                endcase
            end
            default: rule = unused_rule;
        endcase
    end

endmodule

`default_nettype wire
